// ==== build.f ====
pe_set_cfg_pkg.sv
pe_set_cmd_pkg.sv
x_bus_if.sv
x_bus_ctrl.sv
tag_alloc.sv
glb_pe.sv
psum_collect.sv
glb_pe_set.sv
pe_set_props.sv
pe_set_checker.sv
tb_glb_pe_set.sv

// ==== glb_pe.sv ====
`timescale 1ns/10ps
`default_nettype none

module glb_pe
    import pe_set_cfg_pkg::*, pe_set_cmd_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic [TAG_WIDTH-1:0]    tag,
    input  wire logic                    tag_lock,
    x_bus_if.pe                          bus,
    input  wire logic                    psum_take,
    output logic                         psum_pending,
    output logic signed [ACC_WIDTH-1:0]  psum_value
);

    logic signed [DATA_WIDTH-1:0] w_mem [KERNEL_MAX];
    logic        [PTR_WIDTH-1:0]  wr_ptr;
    logic        [PTR_WIDTH-1:0]  rd_ptr;
    logic signed [ACC_WIDTH-1:0]  acc;

    logic                         hit;
    logic                         do_load;
    logic                         do_stream;
    logic        [KSIZE_WIDTH-1:0] k_last;
    logic                         wr_last;
    logic                         rd_last;
    logic signed [ACC_WIDTH-1:0]  prod;
    logic signed [ACC_WIDTH-1:0]  acc_sum;
    logic                         psum_load;

    // Locked columns never answer
    assign hit       = bus.bus_valid && !tag_lock && (bus.bus_tag == tag);
    assign do_load   = hit && (bus.bus_op == OP_LOAD_WEIGHT);
    assign do_stream = hit && (bus.bus_op == OP_STREAM_IFMAP);

    assign k_last  = bus.k_size - 1'b1;
    assign wr_last = (KSIZE_WIDTH'(wr_ptr) == k_last);
    assign rd_last = (KSIZE_WIDTH'(rd_ptr) == k_last);

    // Signed MAC in accumulator width
    assign prod    = bus.bus_data * w_mem[rd_ptr];
    assign acc_sum = acc + prod;

    // New sum is dropped while the old one is still held
    assign psum_load = do_stream && rd_last && (!psum_pending || psum_take);

    ////////////////////////////////////////////////////////////////////////////
    // Weight slots
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bus.wclr) begin
            w_mem[bus.wclr_idx] <= '0;
        end else if (do_load) begin
            w_mem[wr_ptr] <= bus.bus_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and accumulator
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || bus.wclr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            acc    <= '0;
        end else begin
            if (do_load) begin
                wr_ptr <= wr_last ? '0 : wr_ptr + 1'b1;
            end
            if (do_stream) begin
                // Window done, restart for the next one
                if (rd_last) begin
                    rd_ptr <= '0;
                    acc    <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                    acc    <= acc_sum;
                end
            end
        end
    end

    // Held sum for the collector
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            psum_pending <= 1'b0;
        end else if (psum_load) begin
            psum_pending <= 1'b1;
        end else if (psum_take) begin
            psum_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (psum_load) begin
            psum_value <= acc_sum;
        end
    end

endmodule

`default_nettype wire

// ==== glb_pe_set.sv ====
`timescale 1ns/10ps
`default_nettype none

module glb_pe_set
    import pe_set_cfg_pkg::*, pe_set_cmd_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          cmd_valid,
    input  wire bus_op_e                       cmd_op,
    input  wire logic        [TAG_WIDTH-1:0]   cmd_tag,
    input  wire logic signed [DATA_WIDTH-1:0]  cmd_data,
    input  wire logic        [KSIZE_WIDTH-1:0] kernel_size,
    input  wire logic                          flush_tag,
    input  wire logic                          flush_kernel,
    output logic                               tag_busy,
    output logic                               kernel_busy,
    output logic                               psum_valid,
    output logic             [COL_WIDTH-1:0]   psum_col,
    output logic signed      [ACC_WIDTH-1:0]   psum_data
);

    x_bus_if x_bus ();

    logic [NUM_COL-1:0][TAG_WIDTH-1:0] tag;
    logic [NUM_COL-1:0]                tag_lock;
    logic [NUM_COL-1:0]                psum_pending;
    logic [NUM_COL-1:0][ACC_WIDTH-1:0] psum_value;
    logic [NUM_COL-1:0]                psum_take;

    x_bus_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_tag      (cmd_tag),
        .cmd_data     (cmd_data),
        .kernel_size  (kernel_size),
        .flush_tag    (flush_tag),
        .flush_kernel (flush_kernel),
        .kernel_busy  (kernel_busy),
        .busy_in      (tag_busy),
        .bus          (x_bus.ctrl)
    );

    tag_alloc u_tag_alloc (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_tag   (flush_tag),
        .kernel_size (kernel_size),
        .tag_busy    (tag_busy),
        .tag         (tag),
        .tag_lock    (tag_lock)
    );

    // One execute stage per column on the shared X bus
    for (genvar i = 0; i < NUM_COL; i++) begin : g_col
        glb_pe u_pe (
            .clk          (clk),
            .rst_n        (rst_n),
            .tag          (tag[i]),
            .tag_lock     (tag_lock[i]),
            .bus          (x_bus.pe),
            .psum_take    (psum_take[i]),
            .psum_pending (psum_pending[i]),
            .psum_value   (psum_value[i])
        );
    end

    psum_collect u_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .psum_pending (psum_pending),
        .psum_value   (psum_value),
        .psum_take    (psum_take),
        .psum_valid   (psum_valid),
        .psum_col     (psum_col),
        .psum_data    (psum_data)
    );

endmodule

`default_nettype wire

// ==== pe_set_cfg_pkg.sv ====
`default_nettype none

package pe_set_cfg_pkg;

    // Array size
    localparam int NUM_COL    = 8;
    localparam int KERNEL_MAX = 8;

    // Datapath widths, weights and ifmap data are signed
    localparam int DATA_WIDTH = 16;
    localparam int ACC_WIDTH  = 40;

    // Column index and group tag, top tag bit marks an unused column
    localparam int COL_WIDTH  = $clog2(NUM_COL);
    localparam int TAG_WIDTH  = $clog2(NUM_COL) + 1;

    // Kernel size runs 1..KERNEL_MAX
    localparam int KSIZE_WIDTH = $clog2(KERNEL_MAX + 1);
    localparam int PTR_WIDTH   = $clog2(KERNEL_MAX);

    // Running group end in the tag sweep, can pass NUM_COL
    localparam int SPAN_WIDTH  = $clog2(NUM_COL + KERNEL_MAX + 1);

endpackage

`default_nettype wire

// ==== pe_set_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module pe_set_checker
    import pe_set_cfg_pkg::*;
(
    input wire logic                        clk,
    input wire logic                        rst_n,
    input wire logic                        tag_busy,
    input wire logic                        kernel_busy,
    input wire logic                        psum_valid,
    input wire logic        [COL_WIDTH-1:0] psum_col,
    input wire logic signed [ACC_WIDTH-1:0] psum_data
);

    int errors = 0;
    int checks = 0;
    int tag_len = 0;
    int kern_len = 0;
    int tag_pulses = 0;
    int kern_pulses = 0;
    logic rst_d = 1'b0;

    // Pending expected sums, oldest first, searched per column
    int                          q_col [$];
    logic signed [ACC_WIDTH-1:0] q_sum [$];

    task automatic expect_sum(input int col, input logic signed [ACC_WIDTH-1:0] sum);
        q_col.push_back(col);
        q_sum.push_back(sum);
    endtask

    function automatic int outstanding();
        return q_col.size();
    endfunction

    task automatic check_beat();
        int idx;
        idx = -1;
        for (int i = q_col.size() - 1; i >= 0; i--) begin
            if (q_col[i] == int'(psum_col)) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("column %0d returned sum %0d that was never expected", psum_col, psum_data);
            errors++;
        end else begin
            checks++;
            if (psum_data !== q_sum[idx]) begin
                $display("error at %0t: column %0d returned %0d, expected %0d",
                         $time, psum_col, psum_data, q_sum[idx]);
                errors++;
            end
            q_col.delete(idx);
            q_sum.delete(idx);
        end
    endtask

    task automatic final_check(input int n_tag, input int n_kern);
        foreach (q_col[i]) begin
            $display("column %0d never returned expected sum %0d", q_col[i], q_sum[i]);
            errors++;
        end
        if (tag_pulses != n_tag || kern_pulses != n_kern) begin
            $display("saw %0d tag_busy and %0d kernel_busy pulses, wanted %0d and %0d",
                     tag_pulses, kern_pulses, n_tag, n_kern);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        rst_d <= rst_n;
        // Outputs right after reset release
        if (rst_n && !rst_d && ({tag_busy, kernel_busy, psum_valid} !== 3'b000)) begin
            $display("error at %0t: busy or valid not low after reset", $time);
            errors++;
        end
        if (rst_n) begin
            if (psum_valid) begin
                check_beat();
            end
            if (tag_busy) begin
                tag_len <= tag_len + 1;
            end else if (tag_len != 0) begin
                tag_pulses++;
                if (tag_len != NUM_COL) begin
                    $display("error at %0t: tag_busy lasted %0d cycles", $time, tag_len);
                    errors++;
                end
                tag_len <= 0;
            end
            if (kernel_busy) begin
                kern_len <= kern_len + 1;
            end else if (kern_len != 0) begin
                kern_pulses++;
                if (kern_len != KERNEL_MAX) begin
                    $display("error at %0t: kernel_busy lasted %0d cycles", $time, kern_len);
                    errors++;
                end
                kern_len <= 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pe_set_cmd_pkg.sv ====
`default_nettype none

package pe_set_cmd_pkg;

    // Host command opcodes, also carried on the X bus
    typedef enum logic [1:0] {
        OP_NOP          = 2'd0,
        OP_LOAD_WEIGHT  = 2'd1,
        OP_STREAM_IFMAP = 2'd2
    } bus_op_e;

    // Tag allocator sweep
    typedef enum logic {
        ALLOC_IDLE  = 1'b0,
        ALLOC_SWEEP = 1'b1
    } alloc_state_e;

    // Weight flush sweep in the bus controller
    typedef enum logic {
        FLUSH_IDLE  = 1'b0,
        FLUSH_SWEEP = 1'b1
    } flush_state_e;

endpackage

`default_nettype wire

// ==== pe_set_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module pe_set_props
    import pe_set_cfg_pkg::*;
(
    input wire logic               clk,
    input wire logic               rst_n,
    input wire logic [NUM_COL-1:0] psum_take,
    input wire logic               bus_valid,
    input wire logic               wclr,
    input wire logic               tag_busy,
    input wire logic               psum_valid
);

    // Collector grants at most one column per cycle
    a_take_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(psum_take))
        else $error("psum_take has more than one bit set");

    // No command on the bus during a weight flush
    a_no_cmd_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_valid && wclr))
        else $error("bus_valid and wclr high together");

    // Tag sweep covers every column once
    a_tag_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tag_busy) |-> tag_busy [*NUM_COL] ##1 !tag_busy)
        else $error("tag_busy pulse has the wrong length");

    a_valid_in_reset: assert property (@(posedge clk)
        !rst_n |=> !psum_valid)
        else $error("psum_valid high during reset");

endmodule

bind glb_pe_set pe_set_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .psum_take  (psum_take),
    .bus_valid  (x_bus.bus_valid),
    .wclr       (x_bus.wclr),
    .tag_busy   (tag_busy),
    .psum_valid (psum_valid)
);

`default_nettype wire

// ==== psum_collect.sv ====
`timescale 1ns/10ps
`default_nettype none

module psum_collect
    import pe_set_cfg_pkg::*;
(
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic [NUM_COL-1:0]                 psum_pending,
    input  wire logic [NUM_COL-1:0][ACC_WIDTH-1:0]  psum_value,
    output logic      [NUM_COL-1:0]                 psum_take,
    output logic                                    psum_valid,
    output logic      [COL_WIDTH-1:0]               psum_col,
    output logic signed [ACC_WIDTH-1:0]             psum_data
);

    logic [NUM_COL-1:0]   eligible;
    logic                 pick_any;
    logic [COL_WIDTH-1:0] pick_idx;

    // Column taken last cycle still shows pending for one more cycle
    assign eligible = psum_pending & ~psum_take;

    // Lowest index wins
    always_comb begin
        pick_any = 1'b0;
        pick_idx = '0;
        for (int i = NUM_COL - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                pick_any = 1'b1;
                pick_idx = COL_WIDTH'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            psum_valid <= 1'b0;
            psum_take  <= '0;
        end else begin
            psum_valid <= pick_any;
            psum_take  <= pick_any ? (NUM_COL'(1) << pick_idx) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pick_any) begin
            psum_col  <= pick_idx;
            psum_data <= psum_value[pick_idx];
        end
    end

endmodule

`default_nettype wire

// ==== tag_alloc.sv ====
`timescale 1ns/10ps
`default_nettype none

module tag_alloc
    import pe_set_cfg_pkg::*, pe_set_cmd_pkg::*;
(
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               flush_tag,
    input  wire logic [KSIZE_WIDTH-1:0]             kernel_size,
    output logic                                    tag_busy,
    output logic      [NUM_COL-1:0][TAG_WIDTH-1:0]  tag,
    output logic      [NUM_COL-1:0]                 tag_lock
);

    alloc_state_e           state;
    logic [COL_WIDTH-1:0]   col_idx;
    logic [PTR_WIDTH-1:0]   in_grp;
    logic [COL_WIDTH-1:0]   grp;
    logic [SPAN_WIDTH-1:0]  grp_end;
    logic [KSIZE_WIDTH-1:0] ks_q;
    logic                   grp_last;
    logic                   col_locked;

    // Last column of the current group
    assign grp_last   = (KSIZE_WIDTH'(in_grp) == ks_q - 1'b1);

    // Group runs past the array, so it is incomplete
    assign col_locked = (grp_end > SPAN_WIDTH'(NUM_COL));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ALLOC_IDLE;
            col_idx  <= '0;
            in_grp   <= '0;
            grp      <= '0;
            grp_end  <= '0;
            ks_q     <= '0;
            tag      <= '1;
            tag_lock <= '1;
        end else begin
            case (state)
                ALLOC_IDLE: begin
                    if (flush_tag) begin
                        state    <= ALLOC_SWEEP;
                        col_idx  <= '0;
                        in_grp   <= '0;
                        grp      <= '0;
                        grp_end  <= SPAN_WIDTH'(kernel_size);
                        ks_q     <= kernel_size;
                        tag_lock <= '1;
                    end
                end
                ALLOC_SWEEP: begin
                    tag[col_idx]      <= {col_locked, grp};
                    tag_lock[col_idx] <= col_locked;
                    if (grp_last) begin
                        in_grp  <= '0;
                        grp     <= grp + 1'b1;
                        grp_end <= grp_end + SPAN_WIDTH'(ks_q);
                    end else begin
                        in_grp <= in_grp + 1'b1;
                    end
                    if (col_idx == COL_WIDTH'(NUM_COL - 1)) begin
                        state <= ALLOC_IDLE;
                    end else begin
                        col_idx <= col_idx + 1'b1;
                    end
                end
                default: state <= ALLOC_IDLE;
            endcase
        end
    end

    assign tag_busy = (state == ALLOC_SWEEP);

endmodule

`default_nettype wire

// ==== tb_glb_pe_set.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_glb_pe_set
    import pe_set_cfg_pkg::*, pe_set_cmd_pkg::*;
();

    typedef enum int {ROW_CMD, ROW_FTAG, ROW_FKERN} row_kind_e;
    localparam int MAX_ROWS = 64;

    logic                          clk;
    logic                          rst_n;
    logic                          cmd_valid;
    bus_op_e                       cmd_op;
    logic        [TAG_WIDTH-1:0]   cmd_tag;
    logic signed [DATA_WIDTH-1:0]  cmd_data;
    logic        [KSIZE_WIDTH-1:0] kernel_size;
    logic                          flush_tag;
    logic                          flush_kernel;
    logic                          tag_busy;
    logic                          kernel_busy;
    logic                          psum_valid;
    logic        [COL_WIDTH-1:0]   psum_col;
    logic signed [ACC_WIDTH-1:0]   psum_data;

    // Stimulus table, one command or flush per row
    row_kind_e                     r_kind [MAX_ROWS];
    bus_op_e                       r_op   [MAX_ROWS];
    logic        [TAG_WIDTH-1:0]   r_tag  [MAX_ROWS];
    logic signed [DATA_WIDTH-1:0]  r_data [MAX_ROWS];
    logic        [KSIZE_WIDTH-1:0] r_ks   [MAX_ROWS];
    int                            r_idle [MAX_ROWS];
    bit                            r_rnd  [MAX_ROWS];
    int                            n_rows = 0;

    // Expected pairs, sum + w * data of the row they hang on
    int     e_row [$];
    int     e_col [$];
    longint e_sum [$];
    longint e_w   [$];

    int seed;
    int cycles = 0;
    int limit = 0;
    int n_ftag = 0;
    int n_fkern = 0;

    glb_pe_set dut (.*);

    pe_set_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input row_kind_e kind, input bus_op_e op, input int tag,
                           input int data, input int ks, input int idle, input bit rnd);
        r_kind[n_rows] = kind;
        r_op[n_rows]   = op;
        r_tag[n_rows]  = TAG_WIDTH'(tag);
        r_data[n_rows] = DATA_WIDTH'(data);
        r_ks[n_rows]   = KSIZE_WIDTH'(ks);
        r_idle[n_rows] = idle;
        r_rnd[n_rows]  = rnd;
        n_rows++;
    endtask

    task automatic add_seq(input bus_op_e op, input int tag, input int n, input int d0,
                           input int d1, input int d2, input int d3, input int idle);
        int d [4];
        d = '{d0, d1, d2, d3};
        for (int i = 0; i < n; i++) begin
            add_row(ROW_CMD, op, tag, d[i], 0, (i == n - 1) ? idle : 0, 1'b0);
        end
    endtask

    // Same sum from n adjacent columns of one group
    task automatic exp_group(input int first, input int n, input longint sum, input longint w);
        for (int i = 0; i < n; i++) begin
            e_row.push_back(n_rows - 1);
            e_col.push_back(first + i);
            e_sum.push_back(sum);
            e_w.push_back(w);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        add_row(ROW_FTAG, OP_NOP, 0, 0, 3, 2, 1'b0);
        add_row(ROW_FKERN, OP_NOP, 0, 0, 0, 2, 1'b0);
        // Kernel 3, weights 3 -2 5 and 7 1 -4
        add_seq(OP_LOAD_WEIGHT, 0, 3, 3, -2, 5, 0, 0);
        add_seq(OP_LOAD_WEIGHT, 1, 3, 7, 1, -4, 0, 0);
        add_seq(OP_STREAM_IFMAP, 0, 3, 10, 20, -3, 0, 2);
        exp_group(0, 3, -25, 0);
        add_seq(OP_STREAM_IFMAP, 1, 3, 2, -6, 9, 0, 2);
        exp_group(3, 3, -28, 0);
        // Columns 6 and 7 carry locked tag 4'b1010 and stay silent
        add_seq(OP_STREAM_IFMAP, 10, 3, 4, 4, 4, 0, 2);
        add_seq(OP_STREAM_IFMAP, 1, 3, 1, 1, 1, 0, 2);
        exp_group(3, 3, 4, 0);
        add_seq(OP_STREAM_IFMAP, 0, 3, 1, 2, 3, 0, 2);
        exp_group(0, 3, 14, 0);
        add_seq(OP_STREAM_IFMAP, 0, 3, -1, -1, -1, 0, 2);
        exp_group(0, 3, -6, 0);
        // Random last element x, sum is 4 + 5x
        add_seq(OP_STREAM_IFMAP, 0, 2, 2, 1, 0, 0, 0);
        add_row(ROW_CMD, OP_STREAM_IFMAP, 0, 0, 0, 2, 1'b1);
        exp_group(0, 3, 4, 5);
        add_row(ROW_FKERN, OP_NOP, 0, 0, 0, 2, 1'b0);
        add_seq(OP_STREAM_IFMAP, 1, 3, 5, 6, 7, 0, 2);
        exp_group(3, 3, 0, 0);
        // Kernel 4, two full groups
        add_row(ROW_FTAG, OP_NOP, 0, 0, 4, 2, 1'b0);
        add_seq(OP_LOAD_WEIGHT, 0, 4, 2, -1, 3, 4, 0);
        add_seq(OP_LOAD_WEIGHT, 1, 4, -5, 6, 0, 2, 0);
        add_seq(OP_STREAM_IFMAP, 0, 4, 1, 2, 3, 4, 2);
        exp_group(0, 4, 25, 0);
        add_seq(OP_STREAM_IFMAP, 1, 4, 3, -2, 8, -7, 2);
        exp_group(4, 4, -41, 0);
    endtask

    task automatic idle_inputs();
        cmd_valid    <= 1'b0;
        flush_tag    <= 1'b0;
        flush_kernel <= 1'b0;
    endtask

    task automatic apply_row(input int r);
        logic signed [DATA_WIDTH-1:0] data;
        logic        [31:0]           rnd_word;
        longint                       sum;
        data = r_data[r];
        if (r_rnd[r]) begin
            rnd_word = $random(seed);
            data     = rnd_word[DATA_WIDTH-1:0];
        end
        @(posedge clk);
        // Commands during a sweep would be dropped
        while (tag_busy || kernel_busy) begin
            @(posedge clk);
        end
        cmd_valid    <= (r_kind[r] == ROW_CMD);
        cmd_op       <= r_op[r];
        cmd_tag      <= r_tag[r];
        cmd_data     <= data;
        flush_tag    <= (r_kind[r] == ROW_FTAG);
        flush_kernel <= (r_kind[r] == ROW_FKERN);
        if (r_kind[r] == ROW_FTAG) begin
            kernel_size <= r_ks[r];
        end
        foreach (e_row[i]) begin
            if (e_row[i] == r) begin
                sum = e_sum[i] + e_w[i] * longint'(data);
                chk.expect_sum(e_col[i], ACC_WIDTH'(sum));
            end
        end
        repeat (r_idle[r]) begin
            @(posedge clk);
            idle_inputs();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = OP_NOP;
        cmd_tag      = '0;
        cmd_data     = '0;
        kernel_size  = '0;
        flush_tag    = 1'b0;
        flush_kernel = 1'b0;
        seed         = 32'h8ef54955;
        build_table();
        limit = 200;
        for (int r = 0; r < n_rows; r++) begin
            limit += 1 + r_idle[r];
            n_ftag += (r_kind[r] == ROW_FTAG) ? 1 : 0;
            n_fkern += (r_kind[r] == ROW_FKERN) ? 1 : 0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        @(posedge clk);
        idle_inputs();
        while (chk.outstanding() != 0) begin
            @(posedge clk);
        end
        // Room for stray sums from locked columns
        repeat (10) @(posedge clk);
        chk.final_check(n_ftag, n_fkern);
        $display("closing: %0d sums compared, %0d errors", chk.checks, chk.errors);
        if (chk.errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run still busy after %0d cycles, %0d sums compared, %0d errors",
                     limit, chk.checks, chk.errors);
            $display("test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== x_bus_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module x_bus_ctrl
    import pe_set_cfg_pkg::*, pe_set_cmd_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          cmd_valid,
    input  wire bus_op_e                       cmd_op,
    input  wire logic        [TAG_WIDTH-1:0]   cmd_tag,
    input  wire logic signed [DATA_WIDTH-1:0]  cmd_data,
    input  wire logic        [KSIZE_WIDTH-1:0] kernel_size,
    input  wire logic                          flush_tag,
    input  wire logic                          flush_kernel,
    output logic                               kernel_busy,
    input  wire logic                          busy_in,
    x_bus_if.ctrl                              bus
);

    flush_state_e flush_state;
    logic         accept;

    ////////////////////////////////////////////////////////////////////////////
    // Command decode
    ////////////////////////////////////////////////////////////////////////////

    // Drop anything that collides with a sweep or a flush request
    assign accept = cmd_valid && !busy_in && !kernel_busy &&
                    !flush_kernel && !flush_tag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.bus_valid <= 1'b0;
        end else begin
            bus.bus_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        bus.bus_op <= accept ? cmd_op : OP_NOP;
        if (accept) begin
            bus.bus_tag  <= cmd_tag;
            bus.bus_data <= cmd_data;
        end
    end

    // Kernel size follows the tag sweep that starts on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.k_size <= '0;
        end else if (flush_tag && !busy_in) begin
            bus.k_size <= kernel_size;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Weight flush sweep
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_state  <= FLUSH_IDLE;
            bus.wclr_idx <= '0;
        end else begin
            case (flush_state)
                FLUSH_IDLE: begin
                    if (flush_kernel) begin
                        flush_state  <= FLUSH_SWEEP;
                        bus.wclr_idx <= '0;
                    end
                end
                FLUSH_SWEEP: begin
                    if (bus.wclr_idx == PTR_WIDTH'(KERNEL_MAX - 1)) begin
                        flush_state <= FLUSH_IDLE;
                    end else begin
                        bus.wclr_idx <= bus.wclr_idx + 1'b1;
                    end
                end
                default: flush_state <= FLUSH_IDLE;
            endcase
        end
    end

    // One slot per cycle, so busy for KERNEL_MAX cycles
    assign kernel_busy = (flush_state == FLUSH_SWEEP);
    assign bus.wclr    = kernel_busy;

endmodule

`default_nettype wire

// ==== x_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface x_bus_if
    import pe_set_cfg_pkg::*, pe_set_cmd_pkg::*;
();

    // Command broadcast, bus_valid strobes for one cycle
    logic                          bus_valid;
    bus_op_e                       bus_op;
    logic        [TAG_WIDTH-1:0]   bus_tag;
    logic signed [DATA_WIDTH-1:0]  bus_data;

    // Kernel size latched at the last tag flush
    logic        [KSIZE_WIDTH-1:0] k_size;

    // Weight flush, one slot per cycle
    logic                          wclr;
    logic        [PTR_WIDTH-1:0]   wclr_idx;

    modport ctrl (
        output bus_valid, bus_op, bus_tag, bus_data,
        output k_size,
        output wclr, wclr_idx
    );

    modport pe (
        input bus_valid, bus_op, bus_tag, bus_data,
        input k_size,
        input wclr, wclr_idx
    );

endinterface

`default_nettype wire
